// ==== rv_core_top.f ====
design/rv_core_pkg.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_result.sv
design/rv_regfile.sv
design/rv_core_top.sv
verification/rv_core_clk_gen.sv
verification/rv_core_sva.sv
verification/rv_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run the simulation and check the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f rv_core_top.f --top-module rv_core_tb \
    -Mdir build -o rv_core_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./build/rv_core_sim > sim.log 2>&1
cat sim.log
grep -q "TESTS PASSED" sim.log && exit 0 || exit 1

// ==== verification/rv_core_tb.sv ====
// Core testbench: stimulus, register model, reference function, compare process and timeout.
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb;

    localparam int NUM_INSTR  = 159;
    localparam int RST_CYCLES = 16;
    localparam int TIMEOUT    = 5 * NUM_INSTR * 4 + RST_CYCLES;

    typedef struct packed {
        logic        legal;
        logic [4:0]  rd;
        logic [63:0] data;
    } expect_t;

    logic        clk;
    logic        rst_n;
    logic        i_instr_valid;
    logic [31:0] i_instr;
    logic        o_ready;
    logic        o_wb_valid;
    logic [4:0]  o_wb_rd;
    logic [63:0] o_wb_data;
    logic        o_illegal;

    logic [63:0] model [0:31];
    logic [31:0] rnd_state = 32'h7ad2_7508;
    logic [31:0] pend_instr [$];
    int          pend_due [$];
    int          cycle;
    string       test_name = "reset";

    rv_core_clk_gen #(.PERIOD_NS (8), .RST_CYCLES (RST_CYCLES)) clk_gen_i (
        .o_clk   ( clk   ),
        .o_rst_n ( rst_n )
    );

    rv_core_top #(.XLEN (64)) dut_i (
        .clk           ( clk           ),
        .i_rst_n       ( rst_n         ),
        .i_instr_valid ( i_instr_valid ),
        .i_instr       ( i_instr       ),
        .o_ready       ( o_ready       ),
        .o_wb_valid    ( o_wb_valid    ),
        .o_wb_rd       ( o_wb_rd       ),
        .o_wb_data     ( o_wb_data     ),
        .o_illegal     ( o_illegal     )
    );

    // ----------------------------------------------------------------------
    // Helpers.
    // ----------------------------------------------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rnd_state = xorshift(rnd_state);
        return rnd_state;
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [4:0] r;
        r = 5'(next_rand() >> 7);
        return (r == 5'd0) ? 5'd1 : r;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("** Error %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    // Expected result of one instruction against the register model.
    function automatic expect_t ref_result(input logic [31:0] ins);
        expect_t     r;
        logic [2:0]  f3;
        logic [63:0] a;
        logic [63:0] b;
        logic        alt;
        f3      = ins[14:12];
        a       = model[ins[19:15]];
        b       = model[ins[24:20]];
        alt     = ins[30];
        r.rd    = ins[11:7];
        r.legal = 1'b0;
        r.data  = '0;
        if (ins[6:0] == 7'b0110011) begin
            r.legal = (ins[31:25] == 7'h00) ||
                      ((ins[31:25] == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
        end else if (ins[6:0] == 7'b0010011) begin
            b = {{52{ins[31]}}, ins[31:20]};
            if (f3 == 3'd1) begin
                r.legal = (ins[31:26] == 6'h00);
            end else if (f3 == 3'd5) begin
                r.legal = (ins[31:26] == 6'h00) || (ins[31:26] == 6'h10);
            end else begin
                r.legal = 1'b1;
                alt     = 1'b0;
            end
        end else if (ins[6:0] == 7'b0110111) begin
            r.legal = 1'b1;
            r.data  = {{32{ins[31]}}, ins[31:12], 12'h000};
            return r;
        end
        case (f3)
            3'd0:    r.data = alt ? a - b : a + b;
            3'd1:    r.data = a << b[5:0];
            3'd2:    r.data = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            3'd3:    r.data = (a < b) ? 64'd1 : 64'd0;
            3'd4:    r.data = a ^ b;
            3'd5: begin
                if (alt) begin
                    r.data = $signed(a) >>> b[5:0];
                end else begin
                    r.data = a >> b[5:0];
                end
            end
            3'd6:    r.data = a | b;
            default: r.data = a & b;
        endcase
        return r;
    endfunction

    // Waits for ready, issues one instruction; busy adds strobes while the core works.
    task automatic issue(input logic [31:0] ins, input logic busy);
        do begin
            @(posedge clk);
            #1;
        end while (!o_ready);
        @(posedge clk);
        i_instr_valid <= 1'b1;
        i_instr       <= ins;
        @(negedge clk);
        pend_instr.push_back(ins);
        pend_due.push_back(cycle + 3);
        @(posedge clk);
        if (busy) begin
            i_instr <= enc_i(12'(next_rand() >> 20), rand_reg(), 3'd0, rand_reg());
            repeat (2) @(posedge clk);
        end
        i_instr_valid <= 1'b0;
    endtask

    // ----------------------------------------------------------------------
    // Cycle counter, timeout and compare process.
    // ----------------------------------------------------------------------
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle <= 0;
        end else begin
            cycle <= cycle + 1;
            if (cycle > TIMEOUT) begin
                fail_run("Timeout: the core stopped reporting results within the cycle limit");
            end
        end
    end

    always @(negedge clk) begin : compare_proc
        logic [31:0] ins;
        int          due;
        expect_t     e;
        if (rst_n && (o_wb_valid || o_illegal)) begin
            if (pend_instr.size() == 0) begin
                fail_run("A report came out with no instruction accepted");
            end
            ins = pend_instr.pop_front();
            due = pend_due.pop_front();
            e   = ref_result(ins);
            check_value({test_name, " report cycle"}, 64'(due), 64'(cycle));
            check_value({test_name, " wb_valid"}, 64'(e.legal), 64'(o_wb_valid));
            check_value({test_name, " illegal"}, 64'(!e.legal), 64'(o_illegal));
            if (e.legal) begin
                check_value({test_name, " rd"}, 64'(e.rd), 64'(o_wb_rd));
                check_value({test_name, " data"}, e.data, o_wb_data);
                if (e.rd != 5'd0) begin
                    model[e.rd] = e.data;
                end
            end
        end else if (rst_n && (pend_due.size() > 0) && (cycle >= pend_due[0])) begin
            fail_run({"No report arrived for an accepted instruction in ", test_name});
        end
    end

    // ----------------------------------------------------------------------
    // Stimulus.
    // ----------------------------------------------------------------------
    initial begin : stimulus
        logic [2:0]  r_f3 [10];
        logic [6:0]  r_f7 [10];
        logic [2:0]  i_f3 [8];
        logic [31:0] rnd;
        int          k;
        r_f3 = '{3'd0, 3'd0, 3'd1, 3'd2, 3'd3, 3'd4, 3'd5, 3'd5, 3'd6, 3'd7};
        r_f7 = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00, 7'h20, 7'h00, 7'h00};
        i_f3 = '{3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        i_instr_valid = 1'b0;
        i_instr       = '0;
        wait (rst_n === 1'b1);

        test_name = "initial load";
        for (int r = 1; r < 32; r++) begin
            issue(enc_i(12'(next_rand() >> 20), 5'd0, 3'd0, 5'(r)), 1'b0);
        end

        test_name = "r-type";
        issue(enc_i(12'hffb, 5'd0, 3'd0, 5'd30), 1'b0);
        issue(enc_r(7'h20, 5'd1, 5'd30, 3'd5, 5'd29), 1'b0);
        issue(enc_r(7'h00, 5'd1, 5'd30, 3'd3, 5'd28), 1'b0);
        issue(enc_r(7'h00, 5'd1, 5'd30, 3'd2, 5'd27), 1'b0);
        for (int n = 0; n < 60; n++) begin
            k = int'(next_rand() % 10);
            issue(enc_r(r_f7[k], rand_reg(), rand_reg(), r_f3[k], rand_reg()), 1'b0);
        end

        test_name = "immediate";
        for (int n = 0; n < 40; n++) begin
            k   = n % 8;
            rnd = next_rand();
            if (k >= 5) begin
                rnd[31:26] = (k == 7) ? 6'h10 : 6'h00;
            end
            issue(enc_i(rnd[31:20], rand_reg(), i_f3[k], rand_reg()), 1'b0);
        end
        for (int n = 0; n < 4; n++) begin
            issue({1'b1, 19'(next_rand() >> 13), rand_reg(), 7'b0110111}, 1'b0);
        end

        test_name = "x0 handling";
        issue(enc_i(12'h123, 5'd5, 3'd0, 5'd0), 1'b0);
        issue({20'hfedcb, 5'd0, 7'b0110111}, 1'b0);
        issue(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd6), 1'b0);
        issue(enc_r(7'h00, 5'd5, 5'd0, 3'd0, 5'd7), 1'b0);

        test_name = "illegal";
        issue({25'h0aa5321, 7'b0000011}, 1'b0);
        issue(enc_r(7'h01, 5'd2, 5'd3, 3'd7, 5'd9), 1'b0);
        issue(enc_r(7'h20, 5'd2, 5'd3, 3'd4, 5'd10), 1'b0);
        issue(enc_i(12'h845, 5'd4, 3'd1, 5'd11), 1'b0);
        issue(enc_r(7'h00, 5'd0, 5'd9, 3'd0, 5'd12), 1'b0);
        issue(enc_r(7'h00, 5'd10, 5'd11, 3'd0, 5'd13), 1'b0);
        issue(enc_r(7'h00, 5'd9, 5'd9, 3'd6, 5'd14), 1'b0);
        issue(enc_r(7'h00, 5'd0, 5'd11, 3'd4, 5'd15), 1'b0);

        test_name = "busy strobes";
        for (int n = 0; n < 8; n++) begin
            issue(enc_i(12'(next_rand() >> 20), rand_reg(), 3'd0, rand_reg()), 1'b1);
        end

        while (pend_instr.size() > 0) begin
            @(negedge clk);
        end
        repeat (4) @(posedge clk);
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/rv_core_sva.sv ====
// Concurrent assertions on the core report and ready timing, bound to the top level.
`timescale 1ns/10ps
`default_nettype none

module rv_core_sva (
    input logic clk,
    input logic i_rst_n,
    input logic i_instr_valid,
    input logic o_ready,
    input logic o_wb_valid,
    input logic o_illegal
);

    logic accept;
    logic report;

    assign accept = i_instr_valid && o_ready;
    assign report = o_wb_valid || o_illegal;

    a_exclusive: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(o_wb_valid && o_illegal)) else $error("wb_valid and illegal high together");

    a_wb_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_wb_valid |=> !o_wb_valid) else $error("wb_valid longer than one cycle");

    a_ill_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_illegal |=> !o_illegal) else $error("illegal longer than one cycle");

    // One report, three edges after the accept.
    a_latency: assert property (@(posedge clk) disable iff (!i_rst_n)
        accept |=> !report [*2] ##1 report) else $error("report latency wrong");

    a_busy: assert property (@(posedge clk) disable iff (!i_rst_n)
        accept |=> !o_ready [*3] ##1 o_ready) else $error("ready wrong while busy");

endmodule

bind rv_core_top rv_core_sva sva_i (
    .clk           ( clk           ),
    .i_rst_n       ( i_rst_n       ),
    .i_instr_valid ( i_instr_valid ),
    .o_ready       ( o_ready       ),
    .o_wb_valid    ( o_wb_valid    ),
    .o_illegal     ( o_illegal     )
);

`default_nettype wire

// ==== verification/rv_core_clk_gen.sv ====
// Testbench clock generator and power-on reset.
`timescale 1ns/10ps
`default_nettype none

module rv_core_clk_gen #(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 16
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    // Reset released on a rising edge.
    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// ==== design/rv_core_top.sv ====
// Core top level: decode, execute, result and register file connected.
`timescale 1ns/10ps
`default_nettype none

module rv_core_top
#(
    parameter int XLEN = 64
)
(
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_instr_valid,
    input  rv_core_pkg::instr_t    i_instr,
    output logic                   o_ready,
    output logic                   o_wb_valid,
    output rv_core_pkg::reg_addr_t o_wb_rd,
    output logic [XLEN-1:0]        o_wb_data,
    output logic                   o_illegal
);

    import rv_core_pkg::*;

    // ---------------------------------------------------------------------
    // Internal nets.
    // ---------------------------------------------------------------------

    // Decode outputs.
    reg_addr_t       s_rs1;
    reg_addr_t       s_rs2;
    reg_addr_t       s_rd;
    logic [XLEN-1:0] s_imm_ext;
    alu_ctrl_t       s_alu_ctrl;
    logic            s_use_imm;
    logic            s_opnd_load;
    logic            s_alu_load;
    logic            s_wb_en;
    logic            s_illegal;

    // Datapath.
    logic [XLEN-1:0] s_rs1_data;
    logic [XLEN-1:0] s_rs2_data;
    logic [XLEN-1:0] s_alu_result;
    logic            s_rf_we;
    logic [XLEN-1:0] s_rf_wdata;

    // ---------------------------------------------------------------------
    // Control and decode.
    // ---------------------------------------------------------------------
    rv_decode #(.XLEN (XLEN)) decode_i (
        .clk           ( clk           ),
        .i_rst_n       ( i_rst_n       ),
        .i_instr_valid ( i_instr_valid ),
        .i_instr       ( i_instr       ),
        .o_ready       ( o_ready       ),
        .o_rs1         ( s_rs1         ),
        .o_rs2         ( s_rs2         ),
        .o_rd          ( s_rd          ),
        .o_imm_ext     ( s_imm_ext     ),
        .o_alu_ctrl    ( s_alu_ctrl    ),
        .o_use_imm     ( s_use_imm     ),
        .o_opnd_load   ( s_opnd_load   ),
        .o_alu_load    ( s_alu_load    ),
        .o_wb_en       ( s_wb_en       ),
        .o_illegal     ( s_illegal     )
    );

    // Operands and ALU.
    rv_execute #(.XLEN (XLEN)) execute_i (
        .clk          ( clk          ),
        .i_rst_n      ( i_rst_n      ),
        .i_opnd_load  ( s_opnd_load  ),
        .i_rs1_data   ( s_rs1_data   ),
        .i_rs2_data   ( s_rs2_data   ),
        .i_imm_ext    ( s_imm_ext    ),
        .i_use_imm    ( s_use_imm    ),
        .i_alu_ctrl   ( s_alu_ctrl   ),
        .o_alu_result ( s_alu_result )
    );

    // Result register and writeback report.
    rv_result #(.XLEN (XLEN)) result_i (
        .clk          ( clk          ),
        .i_rst_n      ( i_rst_n      ),
        .i_alu_load   ( s_alu_load   ),
        .i_wb_en      ( s_wb_en      ),
        .i_illegal    ( s_illegal    ),
        .i_alu_result ( s_alu_result ),
        .i_rd         ( s_rd         ),
        .o_rf_we      ( s_rf_we      ),
        .o_rf_wdata   ( s_rf_wdata   ),
        .o_wb_valid   ( o_wb_valid   ),
        .o_wb_rd      ( o_wb_rd      ),
        .o_wb_data    ( o_wb_data    ),
        .o_illegal    ( o_illegal    )
    );

    // Architectural registers.
    rv_regfile #(.XLEN (XLEN)) regfile_i (
        .clk       ( clk        ),
        .i_rst_n   ( i_rst_n    ),
        .i_we      ( s_rf_we    ),
        .i_waddr   ( s_rd       ),
        .i_wdata   ( s_rf_wdata ),
        .i_raddr_1 ( s_rs1      ),
        .i_raddr_2 ( s_rs2      ),
        .o_rdata_1 ( s_rs1_data ),
        .o_rdata_2 ( s_rs2_data )
    );

endmodule

`default_nettype wire

// ==== design/rv_regfile.sv ====
// 32-entry register file, two asynchronous read ports and one write port.
`timescale 1ns/10ps
`default_nettype none

module rv_regfile
#(
    parameter int XLEN = 64
)
(
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_we,
    input  rv_core_pkg::reg_addr_t i_waddr,
    input  logic [XLEN-1:0]        i_wdata,
    input  rv_core_pkg::reg_addr_t i_raddr_1,
    input  rv_core_pkg::reg_addr_t i_raddr_2,
    output logic [XLEN-1:0]        o_rdata_1,
    output logic [XLEN-1:0]        o_rdata_2
);

    // x0 has no storage.
    logic [XLEN-1:0] regs [1:31];

    // ---------------------------------------------------------------------
    // Write port.
    // ---------------------------------------------------------------------
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we && (i_waddr != 5'd0)) begin
            regs[i_waddr] <= i_wdata;
        end
    end

    // ---------------------------------------------------------------------
    // Read ports.
    // ---------------------------------------------------------------------
    always_comb begin
        if (i_raddr_1 == 5'd0) begin
            o_rdata_1 = '0;
        end else begin
            o_rdata_1 = regs[i_raddr_1];
        end
    end

    always_comb begin
        if (i_raddr_2 == 5'd0) begin
            o_rdata_2 = '0;
        end else begin
            o_rdata_2 = regs[i_raddr_2];
        end
    end

endmodule

`default_nettype wire

// ==== design/rv_result.sv ====
// ALU result register, writeback strobe and the writeback report outputs.
`timescale 1ns/10ps
`default_nettype none

module rv_result
#(
    parameter int XLEN = 64
)
(
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_alu_load,
    input  logic                   i_wb_en,
    input  logic                   i_illegal,
    input  logic [XLEN-1:0]        i_alu_result,
    input  rv_core_pkg::reg_addr_t i_rd,
    output logic                   o_rf_we,
    output logic [XLEN-1:0]        o_rf_wdata,
    output logic                   o_wb_valid,
    output rv_core_pkg::reg_addr_t o_wb_rd,
    output logic [XLEN-1:0]        o_wb_data,
    output logic                   o_illegal
);

    logic [XLEN-1:0] alu_q;
    logic            illegal_pulse_q;

    // Result captured at the end of the execute state.
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            alu_q <= '0;
        end else if (i_alu_load) begin
            alu_q <= i_alu_result;
        end
    end

    // Illegal report lines up with the writeback state.
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            illegal_pulse_q <= 1'b0;
        end else begin
            illegal_pulse_q <= i_alu_load && i_illegal;
        end
    end

    // ---------------------------------------------------------------------
    // Register file write port and report outputs.
    // ---------------------------------------------------------------------
    assign o_rf_we    = i_wb_en;
    assign o_rf_wdata = alu_q;

    // Data is reported even for rd 0.
    assign o_wb_valid = i_wb_en;
    assign o_wb_rd    = i_rd;
    assign o_wb_data  = alu_q;
    assign o_illegal  = illegal_pulse_q;

endmodule

`default_nettype wire

// ==== design/rv_execute.sv ====
// Operand registers, operand B select and the combinational ALU.
`timescale 1ns/10ps
`default_nettype none

module rv_execute
#(
    parameter int XLEN = 64
)
(
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_opnd_load,
    input  logic [XLEN-1:0]        i_rs1_data,
    input  logic [XLEN-1:0]        i_rs2_data,
    input  logic [XLEN-1:0]        i_imm_ext,
    input  logic                   i_use_imm,
    input  rv_core_pkg::alu_ctrl_t i_alu_ctrl,
    output logic [XLEN-1:0]        o_alu_result
);

    import rv_core_pkg::*;

    localparam int SHW = $clog2(XLEN);

    logic [XLEN-1:0] rs1_q;
    logic [XLEN-1:0] rs2_q;
    logic [XLEN-1:0] opnd_a;
    logic [XLEN-1:0] opnd_b;
    logic [SHW-1:0]  shamt;

    // ---------------------------------------------------------------------
    // Operand registers, loaded at the end of the decode state.
    // ---------------------------------------------------------------------
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rs1_q <= '0;
            rs2_q <= '0;
        end else if (i_opnd_load) begin
            rs1_q <= i_rs1_data;
            rs2_q <= i_rs2_data;
        end
    end

    assign opnd_a = rs1_q;
    assign opnd_b = i_use_imm ? i_imm_ext : rs2_q;

    // Only the low bits of operand B count for shifts.
    assign shamt = opnd_b[SHW-1:0];

    // ---------------------------------------------------------------------
    // ALU.
    // ---------------------------------------------------------------------
    always_comb begin
        case (i_alu_ctrl)
            ALU_ADD: begin
                o_alu_result = opnd_a + opnd_b;
            end
            ALU_SUB: begin
                o_alu_result = opnd_a - opnd_b;
            end
            ALU_SLL: begin
                o_alu_result = opnd_a << shamt;
            end
            ALU_SLT: begin
                o_alu_result = XLEN'($signed(opnd_a) < $signed(opnd_b));
            end
            ALU_SLTU: begin
                o_alu_result = XLEN'(opnd_a < opnd_b);
            end
            ALU_XOR: begin
                o_alu_result = opnd_a ^ opnd_b;
            end
            ALU_SRL: begin
                o_alu_result = opnd_a >> shamt;
            end
            ALU_SRA: begin
                o_alu_result = $signed(opnd_a) >>> shamt;
            end
            ALU_OR: begin
                o_alu_result = opnd_a | opnd_b;
            end
            ALU_AND: begin
                o_alu_result = opnd_a & opnd_b;
            end
            ALU_PASS_B: begin
                o_alu_result = opnd_b;
            end
            default: begin
                o_alu_result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/rv_decode.sv ====
// Instruction register, sequencing FSM, field decode, ALU control and immediate extension.
`timescale 1ns/10ps
`default_nettype none

module rv_decode
#(
    parameter int XLEN = 64
)
(
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_instr_valid,
    input  rv_core_pkg::instr_t    i_instr,
    output logic                   o_ready,
    output rv_core_pkg::reg_addr_t o_rs1,
    output rv_core_pkg::reg_addr_t o_rs2,
    output rv_core_pkg::reg_addr_t o_rd,
    output logic [XLEN-1:0]        o_imm_ext,
    output rv_core_pkg::alu_ctrl_t o_alu_ctrl,
    output logic                   o_use_imm,
    output logic                   o_opnd_load,
    output logic                   o_alu_load,
    output logic                   o_wb_en,
    output logic                   o_illegal
);

    import rv_core_pkg::*;

    core_state_t     state_q;
    core_state_t     state_d;
    instr_t          instr_q;
    logic            illegal_q;
    logic            illegal_d;
    opcode_t         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic            alt_op;
    logic            shamt_hi_ok;
    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_u;

    // ---------------------------------------------------------------------
    // Sequencing FSM and instruction register.
    // ---------------------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (i_instr_valid) begin
                    state_d = ST_DECODE;
                end
            end
            ST_DECODE:    state_d = ST_EXECUTE;
            ST_EXECUTE:   state_d = ST_WRITEBACK;
            ST_WRITEBACK: state_d = ST_IDLE;
            default:      state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q   <= ST_IDLE;
            instr_q   <= '0;
            illegal_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (o_ready && i_instr_valid) begin
                instr_q <= i_instr;
            end
            // Flag holds until the next instruction is decoded.
            if (state_q == ST_DECODE) begin
                illegal_q <= illegal_d;
            end
        end
    end

    // Field extraction.
    assign opcode = instr_q[6:0];
    assign funct3 = instr_q[14:12];
    assign funct7 = instr_q[31:25];
    assign o_rs1  = instr_q[19:15];
    assign o_rs2  = instr_q[24:20];
    assign o_rd   = instr_q[11:7];

    // Bit 30 selects sub and sra; addi has no subtract form.
    assign alt_op = instr_q[30] && ((opcode == OPC_OP) || (funct3 == 3'b101));

    // A 6-bit shift amount only exists on a 64-bit datapath.
    assign shamt_hi_ok = (XLEN > 32) || !funct7[0];

    // ---------------------------------------------------------------------
    // ALU control and legality.
    // ---------------------------------------------------------------------
    always_comb begin
        case (funct3)
            3'b000:  o_alu_ctrl = alt_op ? ALU_SUB : ALU_ADD;
            3'b001:  o_alu_ctrl = ALU_SLL;
            3'b010:  o_alu_ctrl = ALU_SLT;
            3'b011:  o_alu_ctrl = ALU_SLTU;
            3'b100:  o_alu_ctrl = ALU_XOR;
            3'b101:  o_alu_ctrl = alt_op ? ALU_SRA : ALU_SRL;
            3'b110:  o_alu_ctrl = ALU_OR;
            default: o_alu_ctrl = ALU_AND;
        endcase
        if (opcode == OPC_LUI) begin
            o_alu_ctrl = ALU_PASS_B;
        end
    end

    always_comb begin
        illegal_d = 1'b1;
        case (opcode)
            OPC_OP: begin
                illegal_d = (funct7 != 7'b0000000) &&
                            !((funct7 == 7'b0100000) &&
                              ((funct3 == 3'b000) || (funct3 == 3'b101)));
            end
            OPC_OP_IMM: begin
                if (funct3 == 3'b001) begin
                    illegal_d = (funct7[6:1] != 6'b000000) || !shamt_hi_ok;
                end else if (funct3 == 3'b101) begin
                    illegal_d = ((funct7[6:1] != 6'b000000) && (funct7[6:1] != 6'b010000)) ||
                                !shamt_hi_ok;
                end else begin
                    illegal_d = 1'b0;
                end
            end
            OPC_LUI: illegal_d = 1'b0;
            default: illegal_d = 1'b1;
        endcase
    end

    // Immediates, sign-extended to the datapath width.
    assign imm_i     = XLEN'($signed(instr_q[31:20]));
    assign imm_u     = XLEN'($signed({instr_q[31:12], 12'b0}));
    assign o_imm_ext = (opcode == OPC_LUI) ? imm_u : imm_i;
    assign o_use_imm = (opcode != OPC_OP);

    // Per-state strobes.
    assign o_ready     = (state_q == ST_IDLE);
    assign o_opnd_load = (state_q == ST_DECODE);
    assign o_alu_load  = (state_q == ST_EXECUTE);
    assign o_wb_en     = (state_q == ST_WRITEBACK) && !illegal_q;
    assign o_illegal   = illegal_q;

endmodule

`default_nettype wire

// ==== design/rv_core_pkg.sv ====
// Instruction field types, opcode constants, ALU operation codes and the FSM state type.
`default_nettype none

package rv_core_pkg;

    // Instruction word and field types.
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [3:0]  alu_ctrl_t;

    // Supported major opcodes.
    localparam opcode_t OPC_OP     = 7'b0110011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_LUI    = 7'b0110111;

    // ---------------------------------------------------------------------
    // ALU operation codes.
    // ---------------------------------------------------------------------
    localparam alu_ctrl_t ALU_ADD    = 4'd0;
    localparam alu_ctrl_t ALU_SUB    = 4'd1;
    localparam alu_ctrl_t ALU_SLL    = 4'd2;
    localparam alu_ctrl_t ALU_SLT    = 4'd3;
    localparam alu_ctrl_t ALU_SLTU   = 4'd4;
    localparam alu_ctrl_t ALU_XOR    = 4'd5;
    localparam alu_ctrl_t ALU_SRL    = 4'd6;
    localparam alu_ctrl_t ALU_SRA    = 4'd7;
    localparam alu_ctrl_t ALU_OR     = 4'd8;
    localparam alu_ctrl_t ALU_AND    = 4'd9;
    localparam alu_ctrl_t ALU_PASS_B = 4'd10;   // LUI result is operand B as is.

    // Sequencing states, one instruction at a time.
    typedef enum logic [1:0] {
        ST_IDLE      = 2'd0,
        ST_DECODE    = 2'd1,
        ST_EXECUTE   = 2'd2,
        ST_WRITEBACK = 2'd3
    } core_state_t;

endpackage

`default_nettype wire
